/* verilog/rv_fe_pkg.sv */
// RV32I front end definitions for 32-bit fetch without compressed instructions or debug mode
`default_nettype none

package rv_fe_pkg;

  ////////////////////////////////////////
  // Widths and addresses
  ////////////////////////////////////////

  // Data path width
  localparam int unsigned xlen = 32;

  typedef logic [xlen-1:0] pc_t;
  typedef logic [31:0]     instr_t;
  typedef logic [4:0]      reg_adr_t;
  typedef logic [11:0]     csr_adr_t;

  // Reset address of the program counter
  localparam pc_t pc_init = 32'h200;

  // Clears the two low address bits
  localparam pc_t adr_mask = {{(xlen-2){1'b1}}, 2'b00};

  // Instruction slot as it moves down the pipe
  typedef struct packed {
    instr_t instr;
    logic   bubble;
  } insn_t;

  // Fetch side exceptions
  typedef struct packed {
    logic access_fault;
    logic any;
  } exc_t;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_system = 7'b1110011;

  // SYSTEM funct3 values for the Zicsr group
  localparam logic [2:0] f3_csrrw  = 3'b001;
  localparam logic [2:0] f3_csrrs  = 3'b010;
  localparam logic [2:0] f3_csrrc  = 3'b011;
  localparam logic [2:0] f3_csrrwi = 3'b101;
  localparam logic [2:0] f3_csrrsi = 3'b110;
  localparam logic [2:0] f3_csrrci = 3'b111;

  // ADDI x0,x0,0
  localparam instr_t instr_nop = 32'h0000_0013;

  ////////////////////////////////////////
  // Field decode
  ////////////////////////////////////////

  function automatic logic [6:0] decode_opcode(instr_t instr);
    return instr[6:0];
  endfunction

  function automatic logic [2:0] decode_funct3(instr_t instr);
    return instr[14:12];
  endfunction

  // Also the zimm field of the immediate CSR forms
  function automatic reg_adr_t decode_rs1(instr_t instr);
    return instr[19:15];
  endfunction

  function automatic reg_adr_t decode_rs2(instr_t instr);
    return instr[24:20];
  endfunction

  function automatic csr_adr_t decode_csr_adr(instr_t instr);
    return instr[31:20];
  endfunction

  // J-type offset, sign extended
  function automatic logic [xlen-1:0] decode_imm_j(instr_t instr);
    return {{(xlen-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  endfunction

  // B-type offset, sign extended
  function automatic logic [xlen-1:0] decode_imm_b(instr_t instr);
    return {{(xlen-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  endfunction

endpackage

`default_nettype wire

/* verilog/rv_fetch_if.sv */
// Fetch register contents only with no handshake since the receiver samples them under its own stall
`timescale 1ns/1ps
`default_nettype none

interface rv_fetch_if;

  // Address of the registered word
  rv_fe_pkg::pc_t  pc;
  // Word plus squash flag
  rv_fe_pkg::insn_t insn;
  // Memory error for this word
  rv_fe_pkg::exc_t  exc;
  // Low 2 bits of the fetch address were already clear
  logic             valid_adr;

  modport fetch_mp (
    output pc,
    output insn,
    output exc,
    output valid_adr
  );

  modport pd_mp (
    input pc,
    input insn,
    input exc,
    input valid_adr
  );

endinterface

`default_nettype wire

/* verilog/rv_fetch.sv */
// Instruction memory must return data in the same cycle and misaligned targets are masked
`timescale 1ns/1ps
`default_nettype none

module rv_fetch (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,

  input  wire logic               pd_stall_i,
  input  wire logic               st_flush_i,
  input  wire logic               bu_flush_i,
  input  wire rv_fe_pkg::pc_t     st_nxt_pc_i,
  input  wire rv_fe_pkg::pc_t     bu_nxt_pc_i,
  input  wire logic               pd_latch_nxt_pc_i,
  input  wire rv_fe_pkg::pc_t     pd_nxt_pc_i,

  output rv_fe_pkg::pc_t          imem_adr_o,
  input  wire rv_fe_pkg::instr_t  imem_rdata_i,
  input  wire logic               imem_err_i,

  rv_fetch_if.fetch_mp            fe_o
);

  ////////////////////////////////////////
  // Program counter
  ////////////////////////////////////////

  // Raw value keeps the low bits of a target
  rv_fe_pkg::pc_t    pc_q;
  rv_fe_pkg::pc_t    pc_adr;
  rv_fe_pkg::pc_t    nxt_pc;
  logic              flush;

  // Fetch register
  rv_fe_pkg::pc_t    fe_pc_q;
  rv_fe_pkg::instr_t fe_instr_q;
  logic              fe_valid_adr_q;
  logic              fe_bubble_q;
  rv_fe_pkg::exc_t   fe_exc_q;

  assign flush  = st_flush_i | bu_flush_i;
  assign pc_adr = pc_q & rv_fe_pkg::adr_mask;

  // Memory sees the aligned address
  assign imem_adr_o = pc_adr;

  // State flush wins over branch unit, then predictor
  always_comb begin
    if (st_flush_i) begin
      nxt_pc = st_nxt_pc_i;
    end else if (bu_flush_i) begin
      nxt_pc = bu_nxt_pc_i;
    end else if (pd_latch_nxt_pc_i) begin
      nxt_pc = pd_nxt_pc_i;
    end else if (pd_stall_i) begin
      nxt_pc = pc_q;
    end else begin
      nxt_pc = pc_adr + rv_fe_pkg::pc_t'(4);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q <= rv_fe_pkg::pc_init;
    end else begin
      pc_q <= nxt_pc;
    end
  end

  ////////////////////////////////////////
  // Fetch register
  ////////////////////////////////////////

  // Squash control
  // Redirect kills the wrong-path word behind the jump
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fe_bubble_q <= 1'b1;
      fe_exc_q    <= '0;
    end else if (flush) begin
      fe_bubble_q <= 1'b1;
      fe_exc_q    <= '0;
    end else if (!pd_stall_i) begin
      fe_bubble_q <= pd_latch_nxt_pc_i;
      fe_exc_q    <= '{access_fault: imem_err_i & ~pd_latch_nxt_pc_i,
                       any:          imem_err_i & ~pd_latch_nxt_pc_i};
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (!pd_stall_i) begin
      fe_pc_q        <= pc_adr;
      fe_instr_q     <= imem_rdata_i;
      fe_valid_adr_q <= (pc_q[1:0] == 2'b00);
    end
  end

  assign fe_o.pc        = fe_pc_q;
  assign fe_o.insn      = '{instr: fe_instr_q, bubble: fe_bubble_q};
  assign fe_o.exc       = fe_exc_q;
  assign fe_o.valid_adr = fe_valid_adr_q;

endmodule

`default_nettype wire

/* verilog/rv_predecode.sv */
// Static prediction only and no BPU or debug mode and a CSR stall that waits out id_stall_i
`timescale 1ns/1ps
`default_nettype none

module rv_predecode (
  input  wire logic            clk_i,
  input  wire logic            rst_ni,

  rv_fetch_if.pd_mp            fe_i,

  input  wire logic            id_stall_i,
  input  wire logic            st_flush_i,
  input  wire logic            bu_flush_i,
  input  wire rv_fe_pkg::pc_t  st_nxt_pc_i,
  input  wire rv_fe_pkg::pc_t  bu_nxt_pc_i,
  input  wire logic            pipe_exc_i,

  output logic                 pd_stall_o,
  output rv_fe_pkg::pc_t       pd_pc_o,
  output rv_fe_pkg::insn_t     pd_insn_o,
  output rv_fe_pkg::exc_t      pd_exc_o,
  output rv_fe_pkg::reg_adr_t  pd_rs1_o,
  output rv_fe_pkg::reg_adr_t  pd_rs2_o,
  output rv_fe_pkg::csr_adr_t  pd_csr_adr_o,
  output rv_fe_pkg::pc_t       pd_nxt_pc_o,
  output logic                 pd_latch_nxt_pc_o,
  output logic [1:0]           pd_predict_o
);

  logic                     flush;
  logic [6:0]               opcode;
  logic                     csr_wr;
  logic                     local_stall;
  logic                     fault;

  rv_fe_pkg::instr_t        pd_instr_q;
  logic                     pd_bubble_q;

  logic [rv_fe_pkg::xlen-1:0] imm_j;
  logic [rv_fe_pkg::xlen-1:0] imm_b;
  logic                     is_jal;
  logic                     is_branch;
  logic                     branch_taken;
  logic                     dbranch_taken;

  assign flush  = st_flush_i | bu_flush_i;
  assign opcode = rv_fe_pkg::decode_opcode(fe_i.insn.instr);

  ////////////////////////////////////////
  // CSR write stall
  ////////////////////////////////////////

  // Writes that can change CSR state
  // Set and clear forms with a zero operand only read
  always_comb begin
    csr_wr = 1'b0;
    if (!fe_i.insn.bubble && opcode == rv_fe_pkg::opc_system) begin
      case (rv_fe_pkg::decode_funct3(fe_i.insn.instr))
        rv_fe_pkg::f3_csrrw,
        rv_fe_pkg::f3_csrrwi: csr_wr = 1'b1;
        rv_fe_pkg::f3_csrrs,
        rv_fe_pkg::f3_csrrc,
        rv_fe_pkg::f3_csrrsi,
        rv_fe_pkg::f3_csrrci: csr_wr = |rv_fe_pkg::decode_rs1(fe_i.insn.instr);
        default:              csr_wr = 1'b0;
      endcase
    end
  end

  // One unstalled cycle after the CSR leaves
  // Held through id_stall_i so its bubble still gets inserted
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      local_stall <= 1'b0;
    end else if (flush) begin
      local_stall <= 1'b0;
    end else if (id_stall_i) begin
      local_stall <= local_stall;
    end else if (local_stall) begin
      local_stall <= 1'b0;
    end else if (pipe_exc_i) begin
      local_stall <= 1'b0;
    end else begin
      local_stall <= csr_wr;
    end
  end

  assign pd_stall_o = id_stall_i | local_stall;

  // Early register file and CSR addresses
  assign pd_rs1_o     = rv_fe_pkg::decode_rs1(fe_i.insn.instr);
  assign pd_rs2_o     = rv_fe_pkg::decode_rs2(fe_i.insn.instr);
  assign pd_csr_adr_o = rv_fe_pkg::decode_csr_adr(fe_i.insn.instr);

  ////////////////////////////////////////
  // Pipeline register
  ////////////////////////////////////////

  // Flush target shows up right away
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pd_pc_o <= rv_fe_pkg::pc_init;
    end else if (st_flush_i) begin
      pd_pc_o <= st_nxt_pc_i & rv_fe_pkg::adr_mask;
    end else if (bu_flush_i) begin
      pd_pc_o <= bu_nxt_pc_i & rv_fe_pkg::adr_mask;
    end else if (!pd_stall_o) begin
      pd_pc_o <= fe_i.pc;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pd_instr_q <= rv_fe_pkg::instr_nop;
    end else if (!pd_stall_o) begin
      pd_instr_q <= fe_i.insn.instr;
    end
  end

  // Later-stage exception squashes the slot
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pd_bubble_q <= 1'b1;
    end else if (flush || pipe_exc_i) begin
      pd_bubble_q <= 1'b1;
    end else if (!id_stall_i) begin
      pd_bubble_q <= local_stall | fe_i.insn.bubble;
    end
  end

  assign pd_insn_o = '{instr: pd_instr_q, bubble: pd_bubble_q};

  // Masked fetch address counts as an access fault
  assign fault = fe_i.exc.access_fault | (~fe_i.valid_adr & ~fe_i.insn.bubble);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pd_exc_o <= '0;
    end else if (flush || pipe_exc_i || pd_stall_o) begin
      pd_exc_o <= '0;
    end else begin
      pd_exc_o <= '{access_fault: fault, any: fe_i.exc.any | fault};
    end
  end

  ////////////////////////////////////////
  // Static branch prediction
  ////////////////////////////////////////

  assign imm_j     = rv_fe_pkg::decode_imm_j(fe_i.insn.instr);
  assign imm_b     = rv_fe_pkg::decode_imm_b(fe_i.insn.instr);
  assign is_jal    = (opcode == rv_fe_pkg::opc_jal);
  assign is_branch = (opcode == rv_fe_pkg::opc_branch);

  // JAL always, branches only backward
  assign branch_taken = ~fe_i.insn.bubble &
                        (is_jal | (is_branch & imm_b[rv_fe_pkg::xlen-1]));
  assign pd_nxt_pc_o  = fe_i.pc + (is_jal ? imm_j : imm_b);

  // Taken copy kept only while the slot is held
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dbranch_taken <= 1'b0;
    end else begin
      dbranch_taken <= branch_taken & pd_stall_o;
    end
  end

  // First cycle of a taken slot
  assign pd_latch_nxt_pc_o = branch_taken & ~dbranch_taken;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pd_predict_o <= 2'b00;
    end else if (!pd_stall_o) begin
      pd_predict_o <= {branch_taken, 1'b0};
    end
  end

endmodule

`default_nettype wire

/* verilog/rv_frontend_top.sv */
// Front end top with a same-cycle instruction memory and flush targets from the later stages
`timescale 1ns/1ps
`default_nettype none

module rv_frontend_top (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,

  // Instruction memory
  output wire rv_fe_pkg::pc_t     imem_adr_o,
  input  wire rv_fe_pkg::instr_t  imem_rdata_i,
  input  wire logic               imem_err_i,

  // Flushes
  input  wire logic               st_flush_i,
  input  wire rv_fe_pkg::pc_t     st_nxt_pc_i,
  input  wire logic               bu_flush_i,
  input  wire rv_fe_pkg::pc_t     bu_nxt_pc_i,

  // Later stages
  input  wire logic               id_stall_i,
  input  wire logic               pipe_exc_i,

  // Pre-decode results
  output wire rv_fe_pkg::pc_t     pd_pc_o,
  output wire rv_fe_pkg::instr_t  pd_instr_o,
  output wire logic               pd_bubble_o,
  output wire rv_fe_pkg::exc_t    pd_exc_o,
  output wire rv_fe_pkg::reg_adr_t pd_rs1_o,
  output wire rv_fe_pkg::reg_adr_t pd_rs2_o,
  output wire rv_fe_pkg::csr_adr_t pd_csr_adr_o,
  output wire logic               pd_stall_o,

  // Redirect
  output wire logic               pd_latch_nxt_pc_o,
  output wire rv_fe_pkg::pc_t     pd_nxt_pc_o,
  output wire logic [1:0]         pd_predict_o
);

  rv_fe_pkg::insn_t pd_insn;

  rv_fetch_if fe_bus ();

  rv_fetch i_fetch (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .pd_stall_i        (pd_stall_o),
    .st_flush_i        (st_flush_i),
    .bu_flush_i        (bu_flush_i),
    .st_nxt_pc_i       (st_nxt_pc_i),
    .bu_nxt_pc_i       (bu_nxt_pc_i),
    .pd_latch_nxt_pc_i (pd_latch_nxt_pc_o),
    .pd_nxt_pc_i       (pd_nxt_pc_o),
    .imem_adr_o        (imem_adr_o),
    .imem_rdata_i      (imem_rdata_i),
    .imem_err_i        (imem_err_i),
    .fe_o              (fe_bus)
  );

  rv_predecode i_predecode (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .fe_i              (fe_bus),
    .id_stall_i        (id_stall_i),
    .st_flush_i        (st_flush_i),
    .bu_flush_i        (bu_flush_i),
    .st_nxt_pc_i       (st_nxt_pc_i),
    .bu_nxt_pc_i       (bu_nxt_pc_i),
    .pipe_exc_i        (pipe_exc_i),
    .pd_stall_o        (pd_stall_o),
    .pd_pc_o           (pd_pc_o),
    .pd_insn_o         (pd_insn),
    .pd_exc_o          (pd_exc_o),
    .pd_rs1_o          (pd_rs1_o),
    .pd_rs2_o          (pd_rs2_o),
    .pd_csr_adr_o      (pd_csr_adr_o),
    .pd_nxt_pc_o       (pd_nxt_pc_o),
    .pd_latch_nxt_pc_o (pd_latch_nxt_pc_o),
    .pd_predict_o      (pd_predict_o)
  );

  // Slot split for the outside
  assign pd_instr_o  = pd_insn.instr;
  assign pd_bubble_o = pd_insn.bubble;

endmodule

`default_nettype wire

/* bench/tb_frontend_asserts.sv */
// Control timing of the pre-decode stage checked only while reset is released
`timescale 1ns/1ps
`default_nettype none

module rv_predecode_asserts (
  input wire logic           clk_i,
  input wire logic           rst_ni,
  input wire logic           id_stall_i,
  input wire logic           st_flush_i,
  input wire logic           bu_flush_i,
  input wire logic           local_stall_i,
  input wire logic           latch_nxt_pc_i,
  input wire logic           bubble_i,
  input wire rv_fe_pkg::pc_t pc_i
);

  ////////////////////////////////////////
  // Redirect strobe is a single pulse
  strobe_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    latch_nxt_pc_i |=> !latch_nxt_pc_i)
    else $error("redirect strobe high two cycles in a row");

  // CSR stall ends after one unstalled cycle
  // The CSR stays in place behind a single bubble
  csr_stall_short: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (local_stall_i && !id_stall_i && !st_flush_i && !bu_flush_i)
    |=> !local_stall_i && bubble_i && $stable(pc_i))
    else $error("CSR stall longer than one cycle or its slot was not held");

  // Either flush squashes the next slot and the fetch slot behind it
  flush_bubble: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ($past(st_flush_i || bu_flush_i) || $past(st_flush_i || bu_flush_i, 2)) |-> bubble_i)
    else $error("no bubble in the two cycles after a flush");

endmodule

bind rv_predecode rv_predecode_asserts i_asserts (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .id_stall_i     (id_stall_i),
  .st_flush_i     (st_flush_i),
  .bu_flush_i     (bu_flush_i),
  .local_stall_i  (local_stall),
  .latch_nxt_pc_i (pd_latch_nxt_pc_o),
  .bubble_i       (pd_insn_o.bubble),
  .pc_i           (pd_pc_o)
);

`default_nettype wire

/* bench/tb_frontend.sv */
// Random RV32I program in a same-cycle memory model checked against static prediction rules
`timescale 1ns/1ps
`default_nettype none

module tb_frontend;

  localparam int n_cycles   = 2000;
  localparam int max_cycles = 2 * n_cycles;
  localparam int mem_words  = 256;

  // Instruction kinds of the random program
  localparam int k_addi   = 0;
  localparam int k_jal    = 1;
  localparam int k_bfwd   = 2;
  localparam int k_bbwd   = 3;
  localparam int k_csrrw  = 4;
  localparam int k_csrrs0 = 5;

  logic                clk_i;
  logic                rst_ni;
  rv_fe_pkg::pc_t      imem_adr_o;
  rv_fe_pkg::instr_t   imem_rdata_i;
  logic                imem_err_i;
  logic                st_flush_i;
  rv_fe_pkg::pc_t      st_nxt_pc_i;
  logic                bu_flush_i;
  rv_fe_pkg::pc_t      bu_nxt_pc_i;
  logic                id_stall_i;
  logic                pipe_exc_i;
  rv_fe_pkg::pc_t      pd_pc_o;
  rv_fe_pkg::instr_t   pd_instr_o;
  logic                pd_bubble_o;
  rv_fe_pkg::exc_t     pd_exc_o;
  rv_fe_pkg::reg_adr_t pd_rs1_o;
  rv_fe_pkg::reg_adr_t pd_rs2_o;
  rv_fe_pkg::csr_adr_t pd_csr_adr_o;
  logic                pd_stall_o;
  logic                pd_latch_nxt_pc_o;
  rv_fe_pkg::pc_t      pd_nxt_pc_o;
  logic [1:0]          pd_predict_o;

  // Program image with its generator record
  rv_fe_pkg::instr_t mem [mem_words];
  logic              err_mem [mem_words];
  int                kind_mem [mem_words];
  int                off_mem [mem_words];

  logic [31:0]         lcg_state;
  int                  n_checks;
  int                  n_errors;
  int                  n_insns;
  int                  cycle_cnt;
  // Inputs as seen by the last clock edge
  logic                p_stall, p_st, p_bu, p_exc;
  rv_fe_pkg::pc_t      p_st_pc, p_bu_pc;
  rv_fe_pkg::reg_adr_t p_rs1, p_rs2;
  rv_fe_pkg::csr_adr_t p_csr;
  // Redirect target seen with the last strobe
  rv_fe_pkg::pc_t      p_tgt;
  // Expected flow
  logic                exp_valid;
  rv_fe_pkg::pc_t      exp_pc;
  logic                csr_pend;
  logic                csr_bubble;

  rv_frontend_top i_dut (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .imem_adr_o        (imem_adr_o),
    .imem_rdata_i      (imem_rdata_i),
    .imem_err_i        (imem_err_i),
    .st_flush_i        (st_flush_i),
    .st_nxt_pc_i       (st_nxt_pc_i),
    .bu_flush_i        (bu_flush_i),
    .bu_nxt_pc_i       (bu_nxt_pc_i),
    .id_stall_i        (id_stall_i),
    .pipe_exc_i        (pipe_exc_i),
    .pd_pc_o           (pd_pc_o),
    .pd_instr_o        (pd_instr_o),
    .pd_bubble_o       (pd_bubble_o),
    .pd_exc_o          (pd_exc_o),
    .pd_rs1_o          (pd_rs1_o),
    .pd_rs2_o          (pd_rs2_o),
    .pd_csr_adr_o      (pd_csr_adr_o),
    .pd_stall_o        (pd_stall_o),
    .pd_latch_nxt_pc_o (pd_latch_nxt_pc_o),
    .pd_nxt_pc_o       (pd_nxt_pc_o),
    .pd_predict_o      (pd_predict_o)
  );

  // Same-cycle memory that wraps every 256 words
  assign imem_rdata_i = mem[imem_adr_o[9:2]];
  assign imem_err_i   = err_mem[imem_adr_o[9:2]];

  ////////////////////////////////////////
  // Random numbers and instruction words
  ////////////////////////////////////////

  function automatic logic [31:0] lcg_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Upper bits only since low LCG bits cycle too fast
  function automatic int pick(input int n);
    return int'((lcg_rand() >> 16) % 32'(n));
  endfunction

  function automatic int word_index(input rv_fe_pkg::pc_t pc);
    return int'(pc[9:2]);
  endfunction

  function automatic rv_fe_pkg::instr_t jal_word(input int off);
    logic [20:0] o;
    o = 21'(off);
    return {o[20], o[10:1], o[11], o[19:12], 5'(pick(32)), rv_fe_pkg::opc_jal};
  endfunction

  // Any legal compare from BEQ through BGEU
  function automatic rv_fe_pkg::instr_t branch_word(input int off);
    logic [12:0] o;
    logic [2:0]  f3;
    o  = 13'(off);
    f3 = 3'(pick(6));
    if (f3 >= 3'd2) begin
      f3 = f3 + 3'd2;
    end
    return {o[12], o[10:5], 5'(pick(32)), 5'(pick(32)), f3, o[4:1], o[11],
            rv_fe_pkg::opc_branch};
  endfunction

  function automatic rv_fe_pkg::instr_t csr_word(input logic [2:0] f3, input logic [4:0] rs1);
    return {12'(pick(4096)), rs1, f3, 5'(pick(32)), rv_fe_pkg::opc_system};
  endfunction

  task automatic fill_memory();
    int k;
    int j;
    for (int i = 0; i < mem_words; i++) begin
      k = pick(6);
      // No room for the branch direction at the array ends
      if ((k == k_bbwd && i == 0) || (k == k_bfwd && i == mem_words - 1)) begin
        k = k_addi;
      end
      off_mem[i] = 4;
      case (k)
        k_jal: begin
          j = (i + 1 + pick(mem_words - 1)) % mem_words;
          off_mem[i] = (j - i) * 4;
          mem[i] = jal_word(off_mem[i]);
        end
        k_bfwd: begin
          j = i + 1 + pick(mem_words - 1 - i);
          off_mem[i] = (j - i) * 4;
          mem[i] = branch_word(off_mem[i]);
        end
        k_bbwd: begin
          j = pick(i);
          off_mem[i] = (j - i) * 4;
          mem[i] = branch_word(off_mem[i]);
        end
        k_csrrw:  mem[i] = csr_word(rv_fe_pkg::f3_csrrw, 5'(pick(32)));
        k_csrrs0: mem[i] = csr_word(rv_fe_pkg::f3_csrrs, 5'd0);
        default:  mem[i] = {12'(pick(4096)), 5'(pick(32)), 3'b000, 5'(pick(32)), 7'b0010011};
      endcase
      kind_mem[i] = k;
      err_mem[i]  = (pick(16) == 0);
    end
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // JAL always taken, conditional branch only when backward
  function automatic logic predict_taken(input int k);
    return (k == k_jal) || (k == k_bbwd);
  endfunction

  function automatic rv_fe_pkg::pc_t predict_next_pc(input rv_fe_pkg::pc_t pc);
    int idx;
    idx = word_index(pc);
    if (predict_taken(kind_mem[idx])) begin
      return pc + rv_fe_pkg::pc_t'(off_mem[idx]);
    end
    return pc + 32'd4;
  endfunction

  // CSRRS with rs1 zero only reads
  function automatic logic csr_stalls(input int k);
    return k == k_csrrw;
  endfunction

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    assert (got == exp) else begin
      n_errors++;
      $display("mismatch %s: got %h exp %h", name, got, exp);
    end
  endtask

  // Random stall, flush and exception pulses
  task automatic drive_random();
    int f;
    f = pick(24) == 0 ? pick(3) : 3;
    id_stall_i  <= (pick(4) == 0);
    st_flush_i  <= (f == 0 || f == 2);
    bu_flush_i  <= (f == 1 || f == 2);
    st_nxt_pc_i <= rv_fe_pkg::pc_t'(pick(mem_words) * 4);
    bu_nxt_pc_i <= rv_fe_pkg::pc_t'(pick(mem_words) * 4);
    pipe_exc_i  <= (pick(48) == 0);
  endtask

  ////////////////////////////////////////
  // Compare
  ////////////////////////////////////////

  task automatic review_cycle();
    logic fresh;
    logic hit;
    int   idx;
    int   k;
    fresh = !p_stall && !pd_bubble_o;
    hit   = p_st || p_bu || p_exc;
    idx   = word_index(pd_pc_o);
    k     = kind_mem[idx];
    // Squashed slot where the flush target shows up at once
    if (hit) begin
      expect_eq("pd_bubble_o", pd_bubble_o, 1'b1);
      csr_pend = 1'b0;
    end
    if (p_st) begin
      expect_eq("pd_pc_o", pd_pc_o, p_st_pc);
    end else if (p_bu) begin
      expect_eq("pd_pc_o", pd_pc_o, p_bu_pc);
    end
    // Slot right behind a CSR access
    if (csr_pend && !p_stall) begin
      expect_eq("pd_bubble_o", pd_bubble_o, csr_bubble);
      csr_pend = 1'b0;
    end
    if (fresh) begin
      n_insns++;
      expect_eq("pd_pc_o", pd_pc_o[1:0], 2'b00);
      expect_eq("pd_instr_o", pd_instr_o, mem[idx]);
      expect_eq("pd_rs1_o", p_rs1, mem[idx][19:15]);
      expect_eq("pd_rs2_o", p_rs2, mem[idx][24:20]);
      expect_eq("pd_csr_adr_o", p_csr, mem[idx][31:20]);
      if (exp_valid) begin
        expect_eq("pd_pc_o", pd_pc_o, exp_pc);
      end
      expect_eq("pd_predict_o", pd_predict_o, {predict_taken(k), 1'b0});
      // Strobe was raised while this instruction sat in fetch
      if (predict_taken(k)) begin
        expect_eq("pd_nxt_pc_o", p_tgt, predict_next_pc(pd_pc_o));
      end
      expect_eq("pd_exc_o", pd_exc_o, {err_mem[idx], err_mem[idx]});
      exp_pc    = predict_next_pc(pd_pc_o);
      exp_valid = 1'b1;
      if (k == k_csrrw || k == k_csrrs0) begin
        csr_pend   = 1'b1;
        csr_bubble = csr_stalls(k);
      end
    end
    // Squashed instruction breaks the chain and a flush restarts it
    if (p_exc) begin
      exp_valid = 1'b0;
    end
    if (p_st || p_bu) begin
      exp_pc    = p_st ? p_st_pc : p_bu_pc;
      exp_valid = 1'b1;
    end
  endtask

  always @(negedge clk_i) begin
    if (rst_ni) begin
      review_cycle();
    end
    p_stall = id_stall_i;
    p_st    = st_flush_i;
    p_bu    = bu_flush_i;
    p_exc   = pipe_exc_i;
    p_st_pc = st_nxt_pc_i;
    p_bu_pc = bu_nxt_pc_i;
    p_rs1   = pd_rs1_o;
    p_rs2   = pd_rs2_o;
    p_csr   = pd_csr_adr_o;
    if (pd_latch_nxt_pc_o) begin
      p_tgt = pd_nxt_pc_o;
    end
  end

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < max_cycles) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: run still going after %0d cycles", max_cycles);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    lcg_state   = 32'h4f9de18b;
    rst_ni      = 1'b0;
    id_stall_i  = 1'b0;
    st_flush_i  = 1'b0;
    bu_flush_i  = 1'b0;
    pipe_exc_i  = 1'b0;
    st_nxt_pc_i = '0;
    bu_nxt_pc_i = '0;
    n_checks    = 0;
    n_errors    = 0;
    n_insns     = 0;
    csr_pend    = 1'b0;
    csr_bubble  = 1'b0;
    p_tgt       = '0;
    exp_valid   = 1'b1;
    exp_pc      = rv_fe_pkg::pc_init;
    fill_memory();
    repeat (15) @(posedge clk_i);
    // Reset values
    @(negedge clk_i);
    expect_eq("pd_bubble_o", pd_bubble_o, 1'b1);
    expect_eq("pd_stall_o", pd_stall_o, 1'b0);
    expect_eq("pd_latch_nxt_pc_o", pd_latch_nxt_pc_o, 1'b0);
    expect_eq("pd_exc_o", pd_exc_o, 2'b00);
    expect_eq("pd_pc_o", pd_pc_o, rv_fe_pkg::pc_init);
    @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int c = 0; c < n_cycles; c++) begin
      @(posedge clk_i);
      drive_random();
    end
    @(posedge clk_i);
    id_stall_i <= 1'b0;
    st_flush_i <= 1'b0;
    bu_flush_i <= 1'b0;
    pipe_exc_i <= 1'b0;
    repeat (6) @(posedge clk_i);
    n_checks++;
    assert (n_insns > n_cycles / 8) else begin
      n_errors++;
      $display("too few instructions reached pre-decode: %0d", n_insns);
    end
    $display("checks %0d  errors %0d  instructions %0d", n_checks, n_errors, n_insns);
    if (n_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
verilog/rv_fe_pkg.sv
verilog/rv_fetch_if.sv
verilog/rv_fetch.sv
verilog/rv_predecode.sv
verilog/rv_frontend_top.sv
bench/tb_frontend_asserts.sv
bench/tb_frontend.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the front end testbench with Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_frontend \
  -f tb.f --Mdir obj_dir -o sim_frontend > build.log 2>&1 \
  && ./obj_dir/sim_frontend > sim.log 2>&1 \
  || { cat build.log; echo "build or simulation error"; }

cat sim.log 2>/dev/null

grep -qx "TEST PASSED" sim.log \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }
